/* src/vpu_pkg.sv */
`default_nettype none
// Shared types and constants of the vector execution back end
// Datapath widths, element-width and ALU op codes, register geometry

package vpu_pkg;

        // One datapath word and its byte enables
        typedef logic [31:0] word_t;
        typedef logic [3:0]  byte_mask_t;

        // Element width code, code 3 is unused
        typedef logic [1:0] sew_t;

        localparam sew_t SEW_8  = 2'd0;
        localparam sew_t SEW_16 = 2'd1;
        localparam sew_t SEW_32 = 2'd2;

        typedef logic [1:0] alu_op_t;

        localparam alu_op_t ALU_ADD  = 2'd0;
        localparam alu_op_t ALU_SUB  = 2'd1;
        localparam alu_op_t ALU_MINU = 2'd2;
        localparam alu_op_t ALU_MAXU = 2'd3;

        typedef logic [2:0] instr_id_t;
        typedef logic [4:0] vreg_addr_t;

        // Vector register geometry
        localparam int unsigned VREG_BYTES     = 16;
        localparam int unsigned WORDS_PER_VREG = VREG_BYTES / 4;

        typedef logic [1:0] word_off_t;

        // Writeback source tag
        typedef logic src_t;

        localparam src_t SRC_ALU  = 1'b0;
        localparam src_t SRC_PACK = 1'b1;

endpackage

`default_nettype wire

/* src/vec_alu.sv */
`timescale 1ns/1ps
`default_nettype none
// Vector ALU for one 32-bit word of 8, 16 or 32-bit elements
// Unsigned add, subtract, minimum and maximum with one output register

module vec_alu (
        input  logic                 clk_i,
        input  logic                 async_rst_ni,
        input  logic                 in_valid_i,
        output logic                 in_ready_o,
        input  vpu_pkg::alu_op_t     in_op_i,
        input  vpu_pkg::sew_t        in_eew_i,
        input  vpu_pkg::word_t       in_a_i,
        input  vpu_pkg::word_t       in_b_i,
        input  vpu_pkg::instr_id_t   in_id_i,
        input  vpu_pkg::vreg_addr_t  in_vaddr_i,
        input  vpu_pkg::word_off_t   in_woff_i,
        output logic                 out_valid_o,
        input  logic                 out_ready_i,
        output vpu_pkg::word_t       out_data_o,
        output vpu_pkg::byte_mask_t  out_mask_o,
        output vpu_pkg::instr_id_t   out_id_o,
        output vpu_pkg::vreg_addr_t  out_vaddr_o,
        output vpu_pkg::word_off_t   out_woff_o
);

        logic           is_sub;
        vpu_pkg::word_t b_eff;
        vpu_pkg::word_t sum;
        vpu_pkg::word_t res;
        logic [3:0]     carry_out;

        // Min and max compare through the subtract carry
        assign is_sub = in_op_i != vpu_pkg::ALU_ADD;
        assign b_eff  = is_sub ? ~in_b_i : in_b_i;

        // Byte-sliced adder, chain restarts at each element
        always_comb begin
                logic       carry;
                logic [8:0] byte_sum;
                carry     = 1'b0;
                byte_sum  = '0;
                sum       = '0;
                carry_out = '0;
                for (int i = 0; i < 4; i++) begin
                        if (i == 0 || in_eew_i == vpu_pkg::SEW_8 ||
                            (in_eew_i == vpu_pkg::SEW_16 && i == 2)) begin
                                carry = is_sub;
                        end
                        byte_sum = {1'b0, in_a_i[i*8 +: 8]} + {1'b0, b_eff[i*8 +: 8]} +
                                   9'(carry);
                        sum[i*8 +: 8] = byte_sum[7:0];
                        carry         = byte_sum[8];
                        carry_out[i]  = carry;
                end
        end

        // Carry out of the top byte of an element is set when a >= b
        always_comb begin
                logic [1:0] top;
                logic       a_ge_b;
                top    = '0;
                a_ge_b = 1'b0;
                res    = '0;
                for (int i = 0; i < 4; i++) begin
                        case (in_eew_i)
                                vpu_pkg::SEW_8:  top = 2'(i);
                                vpu_pkg::SEW_16: top = 2'(i) | 2'b01;
                                default:         top = 2'b11;
                        endcase
                        a_ge_b = carry_out[top];
                        case (in_op_i)
                                vpu_pkg::ALU_MINU:
                                        res[i*8 +: 8] = a_ge_b ? in_b_i[i*8 +: 8] : in_a_i[i*8 +: 8];
                                vpu_pkg::ALU_MAXU:
                                        res[i*8 +: 8] = a_ge_b ? in_a_i[i*8 +: 8] : in_b_i[i*8 +: 8];
                                default:
                                        res[i*8 +: 8] = sum[i*8 +: 8];
                        endcase
                end
        end

        assign in_ready_o = ~out_valid_o | out_ready_i;

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (!async_rst_ni) begin
                        out_valid_o <= 1'b0;
                end else if (in_ready_o) begin
                        out_valid_o <= in_valid_i;
                end
        end

        always_ff @(posedge clk_i) begin
                if (in_valid_i && in_ready_o) begin
                        out_data_o  <= res;
                        out_mask_o  <= '1;
                        out_id_o    <= in_id_i;
                        out_vaddr_o <= in_vaddr_i;
                        out_woff_o  <= in_woff_i;
                end
        end

endmodule

`default_nettype wire

/* src/elem_packer.sv */
`timescale 1ns/1ps
`default_nettype none
// Element packer: collects scalar elements into 32-bit destination words
// A word leaves when full or on the last element, with a partial byte mask

module elem_packer (
        input  logic                 clk_i,
        input  logic                 async_rst_ni,
        input  logic                 elem_valid_i,
        output logic                 elem_ready_o,
        input  vpu_pkg::word_t       elem_data_i,
        input  vpu_pkg::sew_t        elem_eew_i,
        input  vpu_pkg::instr_id_t   elem_id_i,
        input  vpu_pkg::vreg_addr_t  elem_vaddr_i,
        input  logic                 elem_last_i,
        output logic                 out_valid_o,
        input  logic                 out_ready_i,
        output vpu_pkg::word_t       out_data_o,
        output vpu_pkg::byte_mask_t  out_mask_o,
        output vpu_pkg::instr_id_t   out_id_o,
        output vpu_pkg::vreg_addr_t  out_vaddr_o,
        output vpu_pkg::word_off_t   out_woff_o
);

        logic [1:0]          fill_q;
        logic [6:0]          cnt_q;
        vpu_pkg::word_t      buf_q;

        logic                elem_fire;
        logic [2:0]          elem_bytes;
        logic [2:0]          new_fill;
        logic                emit;
        vpu_pkg::byte_mask_t elem_be;
        vpu_pkg::byte_mask_t fill_mask;
        vpu_pkg::word_t      shifted;
        vpu_pkg::word_t      new_data;
        vpu_pkg::word_t      word_data;

        assign elem_ready_o = ~out_valid_o | out_ready_i;
        assign elem_fire    = elem_valid_i & elem_ready_o;

        always_comb begin
                case (elem_eew_i)
                        vpu_pkg::SEW_8:  elem_bytes = 3'd1;
                        vpu_pkg::SEW_16: elem_bytes = 3'd2;
                        default:         elem_bytes = 3'd4;
                endcase
        end

        assign new_fill  = {1'b0, fill_q} + elem_bytes;
        assign emit      = new_fill[2] | elem_last_i;
        assign elem_be   = vpu_pkg::byte_mask_t'(((5'd1 << elem_bytes) - 5'd1) << fill_q);
        assign fill_mask = vpu_pkg::byte_mask_t'((5'd1 << new_fill) - 5'd1);
        assign shifted   = elem_data_i << {fill_q, 3'b000};

        // Merge the new element bytes, bytes past the fill point read as zero
        always_comb begin
                for (int b = 0; b < 4; b++) begin
                        new_data[b*8 +: 8]  = elem_be[b] ? shifted[b*8 +: 8] : buf_q[b*8 +: 8];
                        word_data[b*8 +: 8] = fill_mask[b] ? new_data[b*8 +: 8] : 8'h00;
                end
        end

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (!async_rst_ni) begin
                        fill_q      <= '0;
                        cnt_q       <= '0;
                        out_valid_o <= 1'b0;
                end else begin
                        if (elem_ready_o) begin
                                out_valid_o <= elem_valid_i & emit;
                        end
                        if (elem_fire) begin
                                fill_q <= emit ? 2'd0 : new_fill[1:0];
                                if (elem_last_i) begin
                                        cnt_q <= '0;
                                end else if (emit) begin
                                        cnt_q <= cnt_q + 7'd1;
                                end
                        end
                end
        end

        always_ff @(posedge clk_i) begin
                if (elem_fire) begin
                        buf_q <= new_data;
                end
                if (elem_fire && emit) begin
                        out_data_o  <= word_data;
                        out_mask_o  <= fill_mask;
                        out_id_o    <= elem_id_i;
                        out_vaddr_o <= vpu_pkg::vreg_addr_t'(elem_vaddr_i +
                                       cnt_q / vpu_pkg::WORDS_PER_VREG);
                        out_woff_o  <= vpu_pkg::word_off_t'(cnt_q % vpu_pkg::WORDS_PER_VREG);
                end
        end

endmodule

`default_nettype wire

/* src/result_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none
// Round-robin merge of the ALU and packer results onto one writeback register

module result_arbiter (
        input  logic                 clk_i,
        input  logic                 async_rst_ni,
        input  logic                 alu_valid_i,
        output logic                 alu_ready_o,
        input  vpu_pkg::word_t       alu_data_i,
        input  vpu_pkg::byte_mask_t  alu_mask_i,
        input  vpu_pkg::instr_id_t   alu_id_i,
        input  vpu_pkg::vreg_addr_t  alu_vaddr_i,
        input  vpu_pkg::word_off_t   alu_woff_i,
        input  logic                 pack_valid_i,
        output logic                 pack_ready_o,
        input  vpu_pkg::word_t       pack_data_i,
        input  vpu_pkg::byte_mask_t  pack_mask_i,
        input  vpu_pkg::instr_id_t   pack_id_i,
        input  vpu_pkg::vreg_addr_t  pack_vaddr_i,
        input  vpu_pkg::word_off_t   pack_woff_i,
        output logic                 wb_valid_o,
        input  logic                 wb_ready_i,
        output vpu_pkg::src_t        wb_src_o,
        output vpu_pkg::word_t       wb_data_o,
        output vpu_pkg::byte_mask_t  wb_mask_o,
        output vpu_pkg::instr_id_t   wb_id_o,
        output vpu_pkg::vreg_addr_t  wb_vaddr_o,
        output vpu_pkg::word_off_t   wb_woff_o
);

        vpu_pkg::src_t last_grant_q;
        logic          wb_free;

        assign wb_free = ~wb_valid_o | wb_ready_i;

        // ALU wins a tie unless it was granted last
        assign alu_ready_o  = wb_free & alu_valid_i &
                              (~pack_valid_i | last_grant_q == vpu_pkg::SRC_PACK);
        assign pack_ready_o = wb_free & pack_valid_i & ~alu_ready_o;

        always_ff @(posedge clk_i or negedge async_rst_ni) begin
                if (!async_rst_ni) begin
                        wb_valid_o   <= 1'b0;
                        last_grant_q <= vpu_pkg::SRC_PACK;
                end else begin
                        if (wb_free) begin
                                wb_valid_o <= alu_ready_o | pack_ready_o;
                        end
                        if (alu_ready_o) begin
                                last_grant_q <= vpu_pkg::SRC_ALU;
                        end else if (pack_ready_o) begin
                                last_grant_q <= vpu_pkg::SRC_PACK;
                        end
                end
        end

        always_ff @(posedge clk_i) begin
                if (alu_ready_o) begin
                        wb_src_o   <= vpu_pkg::SRC_ALU;
                        wb_data_o  <= alu_data_i;
                        wb_mask_o  <= alu_mask_i;
                        wb_id_o    <= alu_id_i;
                        wb_vaddr_o <= alu_vaddr_i;
                        wb_woff_o  <= alu_woff_i;
                end else if (pack_ready_o) begin
                        wb_src_o   <= vpu_pkg::SRC_PACK;
                        wb_data_o  <= pack_data_i;
                        wb_mask_o  <= pack_mask_i;
                        wb_id_o    <= pack_id_i;
                        wb_vaddr_o <= pack_vaddr_i;
                        wb_woff_o  <= pack_woff_i;
                end
        end

endmodule

`default_nettype wire

/* src/vec_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none
// Vector execution back end: ALU and element packer share one writeback port

module vec_exec_top (
        input  logic                 clk_i,
        input  logic                 async_rst_ni,
        input  logic                 alu_valid_i,
        output logic                 alu_ready_o,
        input  vpu_pkg::alu_op_t     alu_op_i,
        input  vpu_pkg::sew_t        alu_eew_i,
        input  vpu_pkg::word_t       alu_a_i,
        input  vpu_pkg::word_t       alu_b_i,
        input  vpu_pkg::instr_id_t   alu_id_i,
        input  vpu_pkg::vreg_addr_t  alu_vaddr_i,
        input  vpu_pkg::word_off_t   alu_woff_i,
        input  logic                 elem_valid_i,
        output logic                 elem_ready_o,
        input  vpu_pkg::word_t       elem_data_i,
        input  vpu_pkg::sew_t        elem_eew_i,
        input  vpu_pkg::instr_id_t   elem_id_i,
        input  vpu_pkg::vreg_addr_t  elem_vaddr_i,
        input  logic                 elem_last_i,
        output logic                 wb_valid_o,
        input  logic                 wb_ready_i,
        output vpu_pkg::src_t        wb_src_o,
        output vpu_pkg::word_t       wb_data_o,
        output vpu_pkg::byte_mask_t  wb_mask_o,
        output vpu_pkg::instr_id_t   wb_id_o,
        output vpu_pkg::vreg_addr_t  wb_vaddr_o,
        output vpu_pkg::word_off_t   wb_woff_o
);

        // ALU result channel
        logic                alu_res_valid;
        logic                alu_res_ready;
        vpu_pkg::word_t      alu_res_data;
        vpu_pkg::byte_mask_t alu_res_mask;
        vpu_pkg::instr_id_t  alu_res_id;
        vpu_pkg::vreg_addr_t alu_res_vaddr;
        vpu_pkg::word_off_t  alu_res_woff;

        // Packer result channel
        logic                pack_res_valid;
        logic                pack_res_ready;
        vpu_pkg::word_t      pack_res_data;
        vpu_pkg::byte_mask_t pack_res_mask;
        vpu_pkg::instr_id_t  pack_res_id;
        vpu_pkg::vreg_addr_t pack_res_vaddr;
        vpu_pkg::word_off_t  pack_res_woff;

        vec_alu u_alu (
                .clk_i        ( clk_i         ),
                .async_rst_ni ( async_rst_ni  ),
                .in_valid_i   ( alu_valid_i   ),
                .in_ready_o   ( alu_ready_o   ),
                .in_op_i      ( alu_op_i      ),
                .in_eew_i     ( alu_eew_i     ),
                .in_a_i       ( alu_a_i       ),
                .in_b_i       ( alu_b_i       ),
                .in_id_i      ( alu_id_i      ),
                .in_vaddr_i   ( alu_vaddr_i   ),
                .in_woff_i    ( alu_woff_i    ),
                .out_valid_o  ( alu_res_valid ),
                .out_ready_i  ( alu_res_ready ),
                .out_data_o   ( alu_res_data  ),
                .out_mask_o   ( alu_res_mask  ),
                .out_id_o     ( alu_res_id    ),
                .out_vaddr_o  ( alu_res_vaddr ),
                .out_woff_o   ( alu_res_woff  )
        );

        elem_packer u_packer (
                .clk_i        ( clk_i          ),
                .async_rst_ni ( async_rst_ni   ),
                .elem_valid_i ( elem_valid_i   ),
                .elem_ready_o ( elem_ready_o   ),
                .elem_data_i  ( elem_data_i    ),
                .elem_eew_i   ( elem_eew_i     ),
                .elem_id_i    ( elem_id_i      ),
                .elem_vaddr_i ( elem_vaddr_i   ),
                .elem_last_i  ( elem_last_i    ),
                .out_valid_o  ( pack_res_valid ),
                .out_ready_i  ( pack_res_ready ),
                .out_data_o   ( pack_res_data  ),
                .out_mask_o   ( pack_res_mask  ),
                .out_id_o     ( pack_res_id    ),
                .out_vaddr_o  ( pack_res_vaddr ),
                .out_woff_o   ( pack_res_woff  )
        );

        result_arbiter u_arbiter (
                .clk_i        ( clk_i          ),
                .async_rst_ni ( async_rst_ni   ),
                .alu_valid_i  ( alu_res_valid  ),
                .alu_ready_o  ( alu_res_ready  ),
                .alu_data_i   ( alu_res_data   ),
                .alu_mask_i   ( alu_res_mask   ),
                .alu_id_i     ( alu_res_id     ),
                .alu_vaddr_i  ( alu_res_vaddr  ),
                .alu_woff_i   ( alu_res_woff   ),
                .pack_valid_i ( pack_res_valid ),
                .pack_ready_o ( pack_res_ready ),
                .pack_data_i  ( pack_res_data  ),
                .pack_mask_i  ( pack_res_mask  ),
                .pack_id_i    ( pack_res_id    ),
                .pack_vaddr_i ( pack_res_vaddr ),
                .pack_woff_i  ( pack_res_woff  ),
                .wb_valid_o   ( wb_valid_o     ),
                .wb_ready_i   ( wb_ready_i     ),
                .wb_src_o     ( wb_src_o       ),
                .wb_data_o    ( wb_data_o      ),
                .wb_mask_o    ( wb_mask_o      ),
                .wb_id_o      ( wb_id_o        ),
                .wb_vaddr_o   ( wb_vaddr_o     ),
                .wb_woff_o    ( wb_woff_o      )
        );

endmodule

`default_nettype wire

/* tb/vec_exec_assert.sv */
`timescale 1ns/1ps
`default_nettype none
// Assertions on the result arbiter for reset state, writeback hold and grant sources

module vec_exec_assert (
        input logic                clk_i,
        input logic                async_rst_ni,
        input logic                alu_valid_i,
        input logic                pack_valid_i,
        input logic                wb_valid_i,
        input logic                wb_ready_i,
        input vpu_pkg::src_t       wb_src_i,
        input vpu_pkg::word_t      wb_data_i,
        input vpu_pkg::byte_mask_t wb_mask_i,
        input vpu_pkg::instr_id_t  wb_id_i,
        input vpu_pkg::vreg_addr_t wb_vaddr_i,
        input vpu_pkg::word_off_t  wb_woff_i
);

        int failures = 0;

        reset_clears_valid: assert property (@(posedge clk_i)
                !async_rst_ni |-> !wb_valid_i)
                else begin
                        failures++;
                        $error("writeback valid high during reset");
                end

        // Stalled writeback keeps its payload and source
        stall_holds_payload: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                wb_valid_i && !wb_ready_i |=> wb_valid_i && $stable(wb_src_i) &&
                $stable(wb_data_i) && $stable(wb_mask_i) && $stable(wb_id_i) &&
                $stable(wb_vaddr_i) && $stable(wb_woff_i))
                else begin
                        failures++;
                        $error("writeback payload changed while stalled");
                end

        // A newly loaded writeback entry comes from a source that was valid
        grant_needs_valid: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
                (!wb_valid_i || wb_ready_i) |=> (!wb_valid_i ||
                (wb_src_i == vpu_pkg::SRC_ALU ? $past(alu_valid_i) : $past(pack_valid_i))))
                else begin
                        failures++;
                        $error("writeback entry loaded from a source without valid");
                end

endmodule

bind result_arbiter vec_exec_assert u_assert (
        .clk_i        ( clk_i        ),
        .async_rst_ni ( async_rst_ni ),
        .alu_valid_i  ( alu_valid_i  ),
        .pack_valid_i ( pack_valid_i ),
        .wb_valid_i   ( wb_valid_o   ),
        .wb_ready_i   ( wb_ready_i   ),
        .wb_src_i     ( wb_src_o     ),
        .wb_data_i    ( wb_data_o    ),
        .wb_mask_i    ( wb_mask_o    ),
        .wb_id_i      ( wb_id_o      ),
        .wb_vaddr_i   ( wb_vaddr_o   ),
        .wb_woff_i    ( wb_woff_o    )
);

`default_nettype wire

/* tb/vec_exec_tb.sv */
`timescale 1ns/1ps
`default_nettype none
// Testbench for the vector execution back end
// Random ALU and packer traffic under writeback stalls, checked against a model

module vec_exec_tb;

        localparam int ALU_OPS      = 300;
        localparam int ELEM_INSTRS  = 60;
        localparam int MAX_ELEMS    = 12;
        localparam int WATCHDOG_CYC = 20 * (ALU_OPS + ELEM_INSTRS * MAX_ELEMS) + 1000;

        logic                clk;
        logic                rst_n;
        logic                alu_valid;
        logic                alu_ready;
        vpu_pkg::alu_op_t    alu_op;
        vpu_pkg::sew_t       alu_eew;
        vpu_pkg::word_t      alu_a;
        vpu_pkg::word_t      alu_b;
        vpu_pkg::instr_id_t  alu_id;
        vpu_pkg::vreg_addr_t alu_vaddr;
        vpu_pkg::word_off_t  alu_woff;
        logic                elem_valid;
        logic                elem_ready;
        vpu_pkg::word_t      elem_data;
        vpu_pkg::sew_t       elem_eew;
        vpu_pkg::instr_id_t  elem_id;
        vpu_pkg::vreg_addr_t elem_vaddr;
        logic                elem_last;
        logic                wb_valid;
        logic                wb_ready;
        vpu_pkg::src_t       wb_src;
        vpu_pkg::word_t      wb_data;
        vpu_pkg::byte_mask_t wb_mask;
        vpu_pkg::instr_id_t  wb_id;
        vpu_pkg::vreg_addr_t wb_vaddr;
        vpu_pkg::word_off_t  wb_woff;

        // Expected results as {src, data, mask, id, vaddr, woff}
        logic [46:0] alu_q[$];
        logic [46:0] pack_q[$];
        logic        seen_input;

        vec_exec_top uut (
                .clk_i(clk), .async_rst_ni(rst_n),
                .alu_valid_i(alu_valid), .alu_ready_o(alu_ready), .alu_op_i(alu_op),
                .alu_eew_i(alu_eew), .alu_a_i(alu_a), .alu_b_i(alu_b), .alu_id_i(alu_id),
                .alu_vaddr_i(alu_vaddr), .alu_woff_i(alu_woff),
                .elem_valid_i(elem_valid), .elem_ready_o(elem_ready), .elem_data_i(elem_data),
                .elem_eew_i(elem_eew), .elem_id_i(elem_id), .elem_vaddr_i(elem_vaddr),
                .elem_last_i(elem_last),
                .wb_valid_o(wb_valid), .wb_ready_i(wb_ready), .wb_src_o(wb_src),
                .wb_data_o(wb_data), .wb_mask_o(wb_mask), .wb_id_o(wb_id),
                .wb_vaddr_o(wb_vaddr), .wb_woff_o(wb_woff)
        );

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        task automatic stop_with_failure(input string msg);
                $display("Failure at time %0t: %s", $time, msg);
                $display("TEST FAIL");
                $fatal(1, "run stopped");
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
                if (got !== exp) begin
                        $display("Error at time %0t: %s got 0x%0h expected 0x%0h",
                                 $time, name, got, exp);
                        $display("TEST FAIL");
                        $fatal(1, "value mismatch");
                end
        endtask

        // Element-wise reference with each lane taken as an unsigned integer
        function automatic vpu_pkg::word_t alu_model(input vpu_pkg::alu_op_t op,
                        input vpu_pkg::sew_t eew, input vpu_pkg::word_t a,
                        input vpu_pkg::word_t b);
                int          w;
                logic [31:0] m;
                logic [31:0] ea;
                logic [31:0] eb;
                logic [31:0] r;
                logic [31:0] res;
                w   = (eew == vpu_pkg::SEW_8) ? 8 : (eew == vpu_pkg::SEW_16) ? 16 : 32;
                m   = (w == 32) ? 32'hffff_ffff : (32'd1 << w) - 32'd1;
                res = '0;
                for (int k = 0; k < 32 / w; k++) begin
                        ea = (a >> (k * w)) & m;
                        eb = (b >> (k * w)) & m;
                        case (op)
                                vpu_pkg::ALU_ADD:  r = (ea + eb) & m;
                                vpu_pkg::ALU_SUB:  r = (ea - eb) & m;
                                vpu_pkg::ALU_MINU: r = (ea < eb) ? ea : eb;
                                default:           r = (ea > eb) ? ea : eb;
                        endcase
                        res = res | (r << (k * w));
                end
                return res;
        endfunction

        task automatic idle_cycles();
                int n;
                n = ($urandom_range(3) == 0) ? $urandom_range(3, 1) : 0;
                repeat (n) begin
                        @(posedge clk);
                        #1;
                end
        endtask

        task automatic drive_alu_op();
                vpu_pkg::word_t res;
                logic           accepted;
                alu_op    = vpu_pkg::alu_op_t'($urandom_range(3));
                alu_eew   = vpu_pkg::sew_t'($urandom_range(2));
                alu_a     = $urandom;
                alu_b     = $urandom;
                alu_id    = vpu_pkg::instr_id_t'($urandom);
                alu_vaddr = vpu_pkg::vreg_addr_t'($urandom);
                alu_woff  = vpu_pkg::word_off_t'($urandom);
                res       = alu_model(alu_op, alu_eew, alu_a, alu_b);
                alu_q.push_back({vpu_pkg::SRC_ALU, res, 4'hf, alu_id, alu_vaddr, alu_woff});
                alu_valid = 1'b1;
                accepted  = 1'b0;
                while (!accepted) begin
                        @(negedge clk);
                        accepted = alu_ready;
                        @(posedge clk);
                        #1;
                end
                alu_valid = 1'b0;
                idle_cycles();
        endtask

        task automatic drive_instr();
                vpu_pkg::sew_t       eew;
                vpu_pkg::instr_id_t  id;
                vpu_pkg::vreg_addr_t base;
                vpu_pkg::word_t      elems[$];
                vpu_pkg::word_t      acc;
                vpu_pkg::byte_mask_t msk;
                int                  n;
                int                  bytes;
                int                  fill;
                int                  cnt;
                logic                accepted;
                n     = $urandom_range(MAX_ELEMS, 1);
                eew   = vpu_pkg::sew_t'($urandom_range(2));
                id    = vpu_pkg::instr_id_t'($urandom);
                base  = vpu_pkg::vreg_addr_t'($urandom);
                bytes = (eew == vpu_pkg::SEW_8) ? 1 : (eew == vpu_pkg::SEW_16) ? 2 : 4;
                fill  = 0;
                cnt   = 0;
                acc   = '0;
                msk   = '0;
                // Expected words fill from byte 0 upward
                for (int k = 0; k < n; k++) begin
                        elems.push_back($urandom);
                        for (int j = 0; j < bytes; j++) begin
                                acc[(fill + j) * 8 +: 8] = elems[k][j * 8 +: 8];
                                msk[fill + j]            = 1'b1;
                        end
                        fill = fill + bytes;
                        if (fill == 4 || k == n - 1) begin
                                pack_q.push_back({vpu_pkg::SRC_PACK, acc, msk, id,
                                                  vpu_pkg::vreg_addr_t'(base + cnt / 4),
                                                  vpu_pkg::word_off_t'(cnt % 4)});
                                cnt  = cnt + 1;
                                fill = 0;
                                acc  = '0;
                                msk  = '0;
                        end
                end
                for (int k = 0; k < n; k++) begin
                        elem_valid = 1'b1;
                        elem_data  = elems[k];
                        elem_eew   = eew;
                        elem_id    = id;
                        elem_vaddr = base;
                        elem_last  = (k == n - 1);
                        accepted   = 1'b0;
                        while (!accepted) begin
                                @(negedge clk);
                                accepted = elem_ready;
                                @(posedge clk);
                                #1;
                        end
                        elem_valid = 1'b0;
                        idle_cycles();
                end
        endtask

        task automatic check_writeback();
                logic [46:0] exp;
                if (wb_src === vpu_pkg::SRC_ALU && alu_q.size() == 0) begin
                        stop_with_failure("ALU result on writeback with none expected");
                end else if (wb_src !== vpu_pkg::SRC_ALU && pack_q.size() == 0) begin
                        stop_with_failure("packer result on writeback with none expected");
                end else begin
                        exp = (wb_src === vpu_pkg::SRC_ALU) ? alu_q.pop_front() :
                                                              pack_q.pop_front();
                        check_value("wb_src_o", wb_src, exp[46]);
                        check_value("wb_data_o", wb_data, exp[45:14]);
                        check_value("wb_mask_o", wb_mask, exp[13:10]);
                        check_value("wb_id_o", wb_id, exp[9:7]);
                        check_value("wb_vaddr_o", wb_vaddr, exp[6:2]);
                        check_value("wb_woff_o", wb_woff, exp[1:0]);
                end
        endtask

        // Sample on the falling edge where inputs and outputs are stable
        always @(negedge clk) begin
                if (uut.u_arbiter.u_assert.failures != 0) begin
                        stop_with_failure("an arbiter assertion failed");
                end
                if (wb_valid !== 1'b0 && !seen_input) begin
                        stop_with_failure("writeback valid before any input was accepted");
                end
                if ((alu_valid && alu_ready) || (elem_valid && elem_ready)) begin
                        seen_input = 1'b1;
                end
                if (rst_n && wb_valid && wb_ready) begin
                        check_writeback();
                end
        end

        initial begin
                repeat (WATCHDOG_CYC) @(posedge clk);
                stop_with_failure("watchdog expired before all results were written back");
        end

        initial begin
                int drain_cnt;
                void'($urandom(32'hf8fe_1872));
                rst_n      = 1'b0;
                seen_input = 1'b0;
                alu_valid  = 1'b0;
                alu_op     = '0;
                alu_eew    = '0;
                alu_a      = '0;
                alu_b      = '0;
                alu_id     = '0;
                alu_vaddr  = '0;
                alu_woff   = '0;
                elem_valid = 1'b0;
                elem_data  = '0;
                elem_eew   = '0;
                elem_id    = '0;
                elem_vaddr = '0;
                elem_last  = 1'b0;
                wb_ready   = 1'b0;
                drain_cnt  = 0;
                repeat (8) @(posedge clk);
                #1;
                rst_n = 1'b1;
                fork
                        forever begin
                                @(posedge clk);
                                #1;
                                wb_ready = ($urandom_range(3) != 0);
                        end
                join_none
                fork
                        repeat (ALU_OPS) drive_alu_op();
                        repeat (ELEM_INSTRS) drive_instr();
                join
                while ((alu_q.size() != 0 || pack_q.size() != 0) && drain_cnt < 200) begin
                        @(posedge clk);
                        drain_cnt++;
                end
                repeat (5) @(posedge clk);
                if (alu_q.size() == 0 && pack_q.size() == 0 &&
                    uut.u_arbiter.u_assert.failures == 0) begin
                        $display("TEST PASS");
                        $finish;
                end else begin
                        $display("Results missing: %0d ALU, %0d packer",
                                 alu_q.size(), pack_q.size());
                        $display("Assertion failures: %0d", uut.u_arbiter.u_assert.failures);
                        $display("TEST FAIL");
                        $fatal(1, "results missing at end of run");
                end
        end

endmodule

`default_nettype wire

/* src.f */
src/vpu_pkg.sv
src/vec_alu.sv
src/elem_packer.sv
src/result_arbiter.sv
src/vec_exec_top.sv
tb/vec_exec_assert.sv
tb/vec_exec_tb.sv
